//--- design/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;

    // Register indices as encoded in opcode fields
    localparam reg_idx_t REG_B   = 3'd0;
    localparam reg_idx_t REG_C   = 3'd1;
    localparam reg_idx_t REG_D   = 3'd2;
    localparam reg_idx_t REG_E   = 3'd3;
    localparam reg_idx_t REG_H   = 3'd4;
    localparam reg_idx_t REG_L   = 3'd5;
    localparam reg_idx_t REG_MEM = 3'd6;   // (HL) operand
    localparam reg_idx_t REG_A   = 3'd7;

    // Opcode bits 5..3 in the ALU groups
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_op_t;

    // Opcode bits 4..3 of JP cc
    typedef enum logic [1:0] {
        COND_NZ = 2'd0,
        COND_Z  = 2'd1,
        COND_NC = 2'd2,
        COND_C  = 2'd3
    } cond_t;

    // Opcode bits 7..6
    typedef enum logic [1:0] {
        GRP_LD_IMM  = 2'b00,
        GRP_LD_REG  = 2'b01,
        GRP_ALU_REG = 2'b10,
        GRP_ALU_IMM = 2'b11
    } opc_grp_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    localparam data_t OPC_NOP        = 8'h00;
    localparam data_t OPC_HALT       = 8'h76;
    localparam data_t OPC_JP         = 8'hC3;
    localparam data_t OPC_JP_CC      = 8'hC2;   // Pattern after masking
    localparam data_t OPC_JP_CC_MASK = 8'hE7;

endpackage

`default_nettype wire

//--- design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_JP_LO,
        S_JP_HI,
        S_HALT
    } state_t;

    // Source of db_address
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_HL
    } addr_sel_t;

    // Source of db_wdata
    typedef enum logic {
        WDATA_REG,
        WDATA_NONE
    } wdata_sel_t;

    // Register file write data
    typedef enum logic [1:0] {
        RFIN_BUS,
        RFIN_ALU,
        RFIN_REG
    } rf_in_sel_t;

    // ALU B operand
    typedef enum logic {
        OPND_REG,
        OPND_BUS
    } opnd_sel_t;

endpackage

`default_nettype wire

//--- design/cpu_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cpu_ctrl_if import cpu_ctrl_pkg::*;;

    addr_sel_t  addr_sel;
    logic       nread;
    logic       nwrite;
    logic       load_ir;
    logic       rf_we;
    rf_in_sel_t rf_in_sel;
    opnd_sel_t  opnd_sel;
    logic       alu_en;
    logic       pc_inc;
    logic       pc_load_lo;
    logic       pc_load_hi;

    modport control (
        output addr_sel, nread, nwrite, load_ir, rf_we, rf_in_sel, opnd_sel,
        output alu_en, pc_inc, pc_load_lo, pc_load_hi
    );

    modport datapath (
        input addr_sel, nread, nwrite, load_ir, rf_we, rf_in_sel, opnd_sel,
        input alu_en, pc_inc, pc_load_lo, pc_load_hi
    );

endinterface

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_isa_pkg::*;
(
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    input  logic    carry_in,
    output data_t   result,
    output flags_t  flags_out
);

    logic [8:0] full;   // Bit 8 is carry or borrow
    logic [4:0] half;
    logic       cin;

    always_comb
    begin
        cin = carry_in && (op == ALU_ADC || op == ALU_SBC);
        full = '0;
        half = '0;
        result = '0;
        flags_out = '0;
        case (op)
            ALU_ADD, ALU_ADC:
            begin
                full = {1'b0, a} + {1'b0, b} + {8'd0, cin};
                half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
                result = full[7:0];
                flags_out.h = half[4];
                flags_out.c = full[8];
            end
            ALU_SUB, ALU_SBC, ALU_CP:
            begin
                full = {1'b0, a} - {1'b0, b} - {8'd0, cin};
                half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
                result = full[7:0];   // CP result only feeds Z
                flags_out.n = 1'b1;
                flags_out.h = half[4];
                flags_out.c = full[8];
            end
            ALU_AND:
            begin
                result = a & b;
                flags_out.h = 1'b1;
            end
            ALU_XOR: result = a ^ b;
            ALU_OR:  result = a | b;
            default: result = '0;
        endcase
        flags_out.z = (result == 8'd0);
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_isa_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  reg_idx_t rd1_idx,
    input  reg_idx_t rd2_idx,
    input  reg_idx_t wr_idx,
    input  data_t    wr_data,
    input  logic     we,
    output data_t    rd1,
    output data_t    rd2,
    output addr_t    hl
);

    data_t regs [8];   // Slot 6 stays unused

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd1 = regs[rd1_idx];
    assign rd2 = regs[rd2_idx];
    assign hl  = {regs[REG_H], regs[REG_L]};

endmodule

`default_nettype wire

//--- design/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit import cpu_isa_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 16'h0000
)
(
    input  logic  clock,
    input  logic  arst_n,
    input  logic  inc,
    input  logic  load_lo,
    input  logic  load_hi,
    input  data_t data,
    input  logic  take,
    output addr_t pc
);

    addr_t pc_q;
    data_t lo_buf;   // Low byte of the jump target

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_q <= RESET_VECTOR;
        end
        else if (load_hi && take)
        begin
            pc_q <= {data, lo_buf};
        end
        else if (inc || load_hi)
        begin
            pc_q <= pc_q + 16'd1;   // Not taken still skips the high byte
        end
    end

    always_ff @(posedge clock)
    begin
        if (load_lo)
            lo_buf <= data;
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

//--- design/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 16'h0000
)
(
    input  logic    clock,
    input  logic    arst_n,
    cpu_ctrl_if.datapath ctrl,
    input  data_t   db_rdata,
    output addr_t   db_address,
    output data_t   db_wdata,
    output logic    db_nread,
    output logic    db_nwrite,
    output data_t   ir,
    output logic    cond_true
);

    flags_t     flags;
    flags_t     alu_flags;
    data_t      alu_b;
    data_t      alu_result;
    data_t      rd1;
    data_t      rd2;
    data_t      wr_data;
    reg_idx_t   wr_idx;
    addr_t      hl;
    addr_t      pc;
    logic       take;
    wdata_sel_t wdata_sel;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ir <= OPC_NOP;
            flags <= '0;
        end
        else
        begin
            if (ctrl.load_ir)
                ir <= db_rdata;
            if (ctrl.alu_en)
                flags <= alu_flags;
        end
    end

    // ALU ops always target A, loads use bits 5..3
    assign wr_idx = (ctrl.rf_in_sel == RFIN_ALU) ? REG_A : reg_idx_t'(ir[5:3]);

    always_comb
    begin
        case (ctrl.rf_in_sel)
            RFIN_ALU: wr_data = alu_result;
            RFIN_REG: wr_data = rd2;
            default:  wr_data = db_rdata;
        endcase
    end

    assign alu_b = (ctrl.opnd_sel == OPND_BUS) ? db_rdata : rd2;

    reg_file reg_file_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .rd1_idx (REG_A),
        .rd2_idx (reg_idx_t'(ir[2:0])),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .we      (ctrl.rf_we),
        .rd1     (rd1),
        .rd2     (rd2),
        .hl      (hl)
    );

    alu alu_i (
        .op        (alu_op_t'(ir[5:3])),
        .a         (rd1),
        .b         (alu_b),
        .carry_in  (flags.c),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    always_comb
    begin
        case (cond_t'(ir[4:3]))
            COND_NZ: cond_true = !flags.z;
            COND_Z:  cond_true = flags.z;
            COND_NC: cond_true = !flags.c;
            default: cond_true = flags.c;
        endcase
    end

    assign take = (ir == OPC_JP) || cond_true;

    pc_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) pc_unit_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .inc     (ctrl.pc_inc),
        .load_lo (ctrl.pc_load_lo),
        .load_hi (ctrl.pc_load_hi),
        .data    (db_rdata),
        .take    (take),
        .pc      (pc)
    );

    assign wdata_sel  = ctrl.nwrite ? WDATA_NONE : WDATA_REG;
    assign db_wdata   = (wdata_sel == WDATA_REG) ? rd2 : 8'h00;
    assign db_address = (ctrl.addr_sel == ADDR_HL) ? hl : pc;
    assign db_nread   = ctrl.nread;
    assign db_nwrite  = ctrl.nwrite;

    // Decode must route every (HL) destination to the bus
    a_no_mem_reg_write: assert property (@(posedge clock) disable iff (!arst_n)
        ctrl.rf_we |-> wr_idx != REG_MEM);

endmodule

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    cpu_ctrl_if.control ctrl,
    input  data_t ir,
    input  data_t db_rdata,
    input  logic  cond_true,
    output logic  halted
);

    state_t   state;
    state_t   state_next;
    logic     started;   // Holds off the first fetch until after reset
    reg_idx_t src;
    reg_idx_t dst;
    alu_op_t  op;

    function automatic state_t fetch_next(data_t opc);
        state_t nxt;
        nxt = S_FETCH;
        if (opc == OPC_HALT)
            nxt = S_HALT;
        else if (opc == OPC_JP || (opc & OPC_JP_CC_MASK) == OPC_JP_CC)
            nxt = S_JP_LO;
        else
        begin
            case (opc_grp_t'(opc[7:6]))
                GRP_LD_REG, GRP_ALU_REG: nxt = S_EXEC;
                default: nxt = (opc[2:0] == 3'b110) ? S_EXEC : S_FETCH;  // Immediates
            endcase
        end
        return nxt;
    endfunction

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= S_FETCH;
            started <= 1'b0;
        end
        else
        begin
            state <= state_next;
            started <= 1'b1;
        end
    end

    assign src = reg_idx_t'(ir[2:0]);
    assign dst = reg_idx_t'(ir[5:3]);
    assign op  = alu_op_t'(ir[5:3]);

    always_comb
    begin
        ctrl.addr_sel = ADDR_PC;
        ctrl.nread = 1'b1;
        ctrl.nwrite = 1'b1;
        ctrl.load_ir = 1'b0;
        ctrl.rf_we = 1'b0;
        ctrl.rf_in_sel = RFIN_BUS;
        ctrl.opnd_sel = OPND_REG;
        ctrl.alu_en = 1'b0;
        ctrl.pc_inc = 1'b0;
        ctrl.pc_load_lo = 1'b0;
        ctrl.pc_load_hi = 1'b0;
        state_next = state;
        case (state)
            S_FETCH:
            begin
                if (started)
                begin
                    ctrl.nread = 1'b0;
                    ctrl.load_ir = 1'b1;
                    ctrl.pc_inc = 1'b1;
                    state_next = fetch_next(db_rdata);
                end
            end
            S_EXEC:
            begin
                state_next = S_FETCH;
                case (opc_grp_t'(ir[7:6]))
                    GRP_LD_IMM:
                    begin
                        ctrl.nread = 1'b0;
                        ctrl.pc_inc = 1'b1;
                        ctrl.rf_we = (dst != REG_MEM);   // LD (HL),n just skips n
                    end
                    GRP_LD_REG:
                    begin
                        if (src == REG_MEM)
                        begin
                            ctrl.addr_sel = ADDR_HL;
                            ctrl.nread = 1'b0;
                            ctrl.rf_we = 1'b1;
                        end
                        else if (dst == REG_MEM)
                        begin
                            ctrl.addr_sel = ADDR_HL;
                            ctrl.nwrite = 1'b0;
                        end
                        else
                        begin
                            ctrl.rf_in_sel = RFIN_REG;
                            ctrl.rf_we = 1'b1;
                        end
                    end
                    GRP_ALU_REG:
                    begin
                        ctrl.alu_en = 1'b1;
                        ctrl.rf_in_sel = RFIN_ALU;
                        ctrl.rf_we = (op != ALU_CP);
                        if (src == REG_MEM)
                        begin
                            ctrl.addr_sel = ADDR_HL;
                            ctrl.nread = 1'b0;
                            ctrl.opnd_sel = OPND_BUS;
                        end
                    end
                    default:
                    begin
                        ctrl.nread = 1'b0;
                        ctrl.pc_inc = 1'b1;
                        ctrl.opnd_sel = OPND_BUS;
                        ctrl.alu_en = 1'b1;
                        ctrl.rf_in_sel = RFIN_ALU;
                        ctrl.rf_we = (op != ALU_CP);
                    end
                endcase
            end
            S_JP_LO:
            begin
                ctrl.nread = 1'b0;
                ctrl.pc_inc = 1'b1;
                ctrl.pc_load_lo = (ir == OPC_JP) || cond_true;   // No target needed otherwise
                state_next = S_JP_HI;
            end
            S_JP_HI:
            begin
                ctrl.nread = 1'b0;
                ctrl.pc_load_hi = 1'b1;   // PC unit picks load or step
                state_next = S_FETCH;
            end
            S_HALT: state_next = S_HALT;
            default: state_next = S_FETCH;
        endcase
    end

    assign halted = (state == S_HALT);

    a_bus_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(!ctrl.nread && !ctrl.nwrite));

    a_halt_sticky: assert property (@(posedge clock) disable iff (!arst_n)
        state == S_HALT |=> state == S_HALT);

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_isa_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 16'h0000
)
(
    input  logic  clock,
    input  logic  arst_n,
    output addr_t db_address,
    input  data_t db_rdata,
    output data_t db_wdata,
    output logic  db_nread,
    output logic  db_nwrite,
    output logic  halted
);

    data_t ir;
    logic  cond_true;

    cpu_ctrl_if ctrl_if_i ();

    control_unit control_unit_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .ctrl      (ctrl_if_i.control),
        .ir        (ir),
        .db_rdata  (db_rdata),
        .cond_true (cond_true),
        .halted    (halted)
    );

    datapath #(
        .RESET_VECTOR (RESET_VECTOR)
    ) datapath_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .ctrl       (ctrl_if_i.datapath),
        .db_rdata   (db_rdata),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite),
        .ir         (ir),
        .cond_true  (cond_true)
    );

endmodule

`default_nettype wire

//--- tb/tb_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory import cpu_isa_pkg::*;
(
    input  logic  clock,
    input  addr_t address,
    output data_t rdata,
    input  data_t wdata,
    input  logic  nread,
    input  logic  nwrite
);

    data_t mem [0:65535];   // Filled by the testbench before reset

    // Same-cycle read with no wait states
    assign rdata = nread ? 8'hFF : mem[address];   // Idle bus floats high

    always @(posedge clock)
    begin
        if (!nwrite)
            mem[address] = wdata;
    end

endmodule

`default_nettype wire

//--- tb/tb_cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core import cpu_isa_pkg::*;;

    localparam addr_t RESET_VECTOR = 16'h0100;
    localparam int K_IDLE  = 0;
    localparam int K_READ  = 1;
    localparam int K_WRITE = 2;

    logic  clock;
    logic  arst_n;
    addr_t db_address;
    data_t db_rdata;
    data_t db_wdata;
    logic  db_nread;
    logic  db_nwrite;
    logic  halted;

    // Expected bus activity for each clock cycle
    int    q_kind [$];
    addr_t q_addr [$];
    data_t q_data [$];
    string q_name [$];
    bit    q_halt [$];

    int    exp_kind;
    addr_t exp_addr;
    data_t exp_data;
    string exp_name;
    bit    exp_halt;
    bit    trace_on;

    // Reference model state
    addr_t pc_m;
    data_t regs_m [8];
    data_t shadow [0:65535];
    bit    fz;
    bit    fn;
    bit    fh;
    bit    fc;
    string cur_test;
    integer seed;
    int    errors;
    int    checked;

    cpu_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) cpu_core_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .db_address (db_address),
        .db_rdata   (db_rdata),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite),
        .halted     (halted)
    );

    tb_memory mem_i (
        .clock   (clock),
        .address (db_address),
        .rdata   (db_rdata),
        .wdata   (db_wdata),
        .nread   (db_nread),
        .nwrite  (db_nwrite)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    a_reset_bus: assert property (@(posedge clock) !arst_n |-> db_nread && db_nwrite)
        else
        begin
            errors++;
            $display("[FAIL] reset: expected nread 1 nwrite 1, actual nread %b nwrite %b",
                     db_nread, db_nwrite);
        end

    a_read: assert property (@(posedge clock)
        trace_on && exp_kind == K_READ |-> !db_nread && db_nwrite && db_address == exp_addr)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected read at %h, actual %h (nread %b nwrite %b)",
                     exp_name, exp_addr, db_address, db_nread, db_nwrite);
        end

    a_write: assert property (@(posedge clock)
        trace_on && exp_kind == K_WRITE |->
            db_nread && !db_nwrite && db_address == exp_addr && db_wdata == exp_data)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected write %h at %h, actual %h at %h (nwrite %b)",
                     exp_name, exp_data, exp_addr, db_wdata, db_address, db_nwrite);
        end

    a_idle: assert property (@(posedge clock)
        trace_on && exp_kind == K_IDLE |-> db_nread && db_nwrite)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected idle bus, actual nread %b nwrite %b",
                     exp_name, db_nread, db_nwrite);
        end

    a_halted: assert property (@(posedge clock) trace_on |-> halted == exp_halt)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected halted %b, actual %b", exp_name, exp_halt, halted);
        end

    task automatic push(input int kind, input addr_t addr, input data_t data, input bit hlt);
        q_kind.push_back(kind);
        q_addr.push_back(addr);
        q_data.push_back(data);
        q_name.push_back(cur_test);
        q_halt.push_back(hlt);
    endtask

    task automatic emit(input data_t b);
        mem_i.mem[pc_m] = b;
        shadow[pc_m] = b;
        pc_m = pc_m + 16'd1;
    endtask

    task automatic fetch(input data_t opc);
        push(K_READ, pc_m, opc, 1'b0);
        emit(opc);
    endtask

    function automatic addr_t hl_m();
        return {regs_m[REG_H], regs_m[REG_L]};
    endfunction

    // Applies the ALU rule table to A and the flags
    task automatic alu_apply(input logic [2:0] op, input data_t b);
        int a;
        int bi;
        int cin;
        int r;
        data_t res;
        a = int'(regs_m[REG_A]);
        bi = int'(b);
        cin = ((op == 3'd1 || op == 3'd3) && fc) ? 1 : 0;
        case (op)
            3'd0, 3'd1:
            begin
                r = a + bi + cin;
                fh = ((a % 16) + (bi % 16) + cin) > 15;
                fc = r > 255;
                fn = 1'b0;
            end
            3'd2, 3'd3, 3'd7:
            begin
                r = a - bi - cin;
                fh = ((a % 16) - (bi % 16) - cin) < 0;
                fc = r < 0;
                fn = 1'b1;
            end
            3'd4:
            begin
                r = a & bi;
                fh = 1'b1;
                fc = 1'b0;
                fn = 1'b0;
            end
            default:
            begin
                r = (op == 3'd5) ? (a ^ bi) : (a | bi);
                fh = 1'b0;
                fc = 1'b0;
                fn = 1'b0;
            end
        endcase
        res = r[7:0];
        fz = (res == 8'd0);
        if (op != 3'd7)
            regs_m[REG_A] = res;   // CP keeps A
    endtask

    task automatic ld_imm(input reg_idx_t d, input data_t n);
        fetch({2'b00, d, 3'b110});
        push(K_READ, pc_m, n, 1'b0);
        emit(n);
        regs_m[d] = n;
    endtask

    task automatic ld_reg(input reg_idx_t d, input reg_idx_t s);
        fetch({2'b01, d, s});
        push(K_IDLE, 16'h0000, 8'h00, 1'b0);
        regs_m[d] = regs_m[s];
    endtask

    task automatic store(input reg_idx_t s);
        fetch({2'b01, REG_MEM, s});
        push(K_WRITE, hl_m(), regs_m[s], 1'b0);
        shadow[hl_m()] = regs_m[s];
    endtask

    task automatic load_mem(input reg_idx_t d);
        fetch({2'b01, d, REG_MEM});
        push(K_READ, hl_m(), shadow[hl_m()], 1'b0);
        regs_m[d] = shadow[hl_m()];
    endtask

    task automatic alu_imm(input logic [2:0] op, input data_t n);
        fetch({2'b11, op, 3'b110});
        push(K_READ, pc_m, n, 1'b0);
        emit(n);
        alu_apply(op, n);
    endtask

    task automatic alu_reg(input logic [2:0] op, input reg_idx_t s);
        data_t b;
        fetch({2'b10, op, s});
        if (s == REG_MEM)
        begin
            b = shadow[hl_m()];
            push(K_READ, hl_m(), b, 1'b0);
        end
        else
        begin
            b = regs_m[s];
            push(K_IDLE, 16'h0000, 8'h00, 1'b0);
        end
        alu_apply(op, b);
    endtask

    // cc 4 means the unconditional JP
    task automatic jump(input int cc, input addr_t target);
        bit taken;
        if (cc == 4)
            fetch(OPC_JP);
        else
            fetch({3'b110, 2'(cc), 3'b010});
        case (cc)
            0: taken = !fz;
            1: taken = fz;
            2: taken = !fc;
            3: taken = fc;
            default: taken = 1'b1;
        endcase
        push(K_READ, pc_m, target[7:0], 1'b0);
        emit(target[7:0]);
        push(K_READ, pc_m, target[15:8], 1'b0);
        emit(target[15:8]);
        if (taken)
            pc_m = target;
    endtask

    task automatic build_program();
        reg_idx_t s;
        for (int i = 0; i < 65536; i++)
        begin
            mem_i.mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
            shadow[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        for (int i = 0; i < 8; i++)
            regs_m[i] = 8'h00;
        {fz, fn, fh, fc} = 4'b0000;
        pc_m = RESET_VECTOR;

        cur_test = "reset_fetch";
        fetch(OPC_NOP);
        cur_test = "reg_load";
        ld_imm(REG_B, 8'($random(seed)));
        ld_imm(REG_C, 8'($random(seed)));
        ld_imm(REG_D, 8'($random(seed)));
        ld_imm(REG_E, 8'($random(seed)));
        ld_imm(REG_A, 8'($random(seed)));
        ld_imm(REG_H, 8'h80);
        ld_imm(REG_L, 8'($random(seed)));
        store(REG_B);
        store(REG_C);
        store(REG_D);
        store(REG_E);
        store(REG_A);
        ld_reg(REG_B, REG_E);
        store(REG_B);
        load_mem(REG_C);

        cur_test = "alu_imm";
        for (int op = 0; op < 8; op++)
        begin
            ld_imm(REG_A, 8'($random(seed)));
            alu_imm(3'(op), 8'($random(seed)));
            store(REG_A);
        end
        cur_test = "alu_reg";
        for (int op = 0; op < 8; op++)
        begin
            s = (op % 3 == 2) ? REG_MEM : reg_idx_t'(op % 4);
            ld_imm(REG_A, 8'($random(seed)));
            alu_reg(3'(op), s);
            store(REG_A);
        end

        cur_test = "jump_cond";
        alu_reg(3'd7, REG_A);   // Z set, C clear
        jump(1, pc_m + 16'd11);
        jump(3, pc_m + 16'd11);
        ld_imm(REG_A, 8'h80);
        alu_imm(3'd0, 8'h80);   // Zero with carry
        jump(0, pc_m + 16'd11);
        jump(2, pc_m + 16'd11);
        jump(3, pc_m + 16'd11);
        for (int k = 0; k < 6; k++)
        begin
            ld_imm(REG_A, 8'($random(seed)));
            alu_imm(3'($random(seed)), 8'($random(seed)));
            jump(k % 4, pc_m + 16'd9);
        end

        cur_test = "jp";
        jump(4, 16'h0400);
        fetch(8'h07);   // Unknown opcode runs as NOP
        fetch(OPC_NOP);

        cur_test = "halt";
        fetch(OPC_HALT);
        for (int i = 0; i < 12; i++)
            push(K_IDLE, 16'h0000, 8'h00, 1'b1);
    endtask

    initial
    begin
        int wait_cycles;
        arst_n = 1'b0;
        trace_on = 1'b0;
        exp_kind = K_IDLE;
        exp_addr = '0;
        exp_data = '0;
        exp_name = "";
        exp_halt = 1'b0;
        errors = 0;
        checked = 0;
        seed = 26;
        build_program();

        repeat (5) @(negedge clock);
        arst_n = 1'b1;

        wait_cycles = 0;
        @(negedge clock);
        while (db_nread && wait_cycles < 20)
        begin
            @(negedge clock);
            wait_cycles++;
        end
        if (db_nread)
        begin
            errors++;
            $display("No opcode fetch seen within 20 cycles after reset");
        end
        else
        begin
            for (int i = 0; i < q_kind.size(); i++)
            begin
                if (i > 0)
                    @(negedge clock);
                exp_kind = q_kind[i];
                exp_addr = q_addr[i];
                exp_data = q_data[i];
                exp_name = q_name[i];
                exp_halt = q_halt[i];
                trace_on = 1'b1;
                checked++;
            end
            @(negedge clock);
            trace_on = 1'b0;
        end

        $display("Errors: %0d, cycles checked: %0d", errors, checked);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_ctrl_if.sv
design/alu.sv
design/reg_file.sv
design/pc_unit.sv
design/datapath.sv
design/control_unit.sv
design/cpu_core.sv
tb/tb_memory.sv
tb/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# Builds with Verilator, runs the testbench and checks the log
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_cpu_core -f flist.f \
    -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
